// File: md4_defs.svh
`ifndef MD4_DEFS_SVH
`define MD4_DEFS_SVH

// width of a digest or message word
`define MD4_WORD_W 32

// words in one 512-bit message block
`define MD4_BLOCK_WORDS 16

// round steps in one compression, three rounds of sixteen
`define MD4_STEPS 48

// additive constants of rounds 2 and 3, round 1 adds zero
`define MD4_K2 32'h5a827999
`define MD4_K3 32'h6ed9eba1

// edges from the edge that samples start to the edge that raises done
`define MD4_DONE_LATENCY 49

`endif

// File: md4Pkg.sv
`include "md4_defs.svh"

package md4Pkg;

  // a is the most significant word
  typedef struct packed {
    logic [`MD4_WORD_W-1:0] a;
    logic [`MD4_WORD_W-1:0] b;
    logic [`MD4_WORD_W-1:0] c;
    logic [`MD4_WORD_W-1:0] d;
  } digestT;

  // word 0 sits at the least significant end
  typedef logic [`MD4_BLOCK_WORDS-1:0][`MD4_WORD_W-1:0] blockT;

  typedef enum logic [1:0] {
    idle   = 2'd0,
    run    = 2'd1,
    finish = 2'd2
  } stateT;

  // select, majority and parity
  typedef enum logic [1:0] {
    funcF = 2'd0,
    funcG = 2'd1,
    funcH = 2'd2
  } roundFuncT;

endpackage

// File: md4Control.sv
`timescale 1ns/100ps

module md4Control (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic lastStep,
  output logic load,
  output logic stepEn,
  output logic finish,
  output logic done
);
  import md4Pkg::*;

  stateT state;
  stateT nextState;

  // start is only taken while idle, a strobe during run is dropped
  assign load = (state == idle) && start;
  assign stepEn = (state == run);

  // the port hides the enum literal of the same name
  assign finish = (state == md4Pkg::finish);

  always_comb
  begin
    nextState = state;
    case (state)
      idle:
      begin
        if (start)
        begin
          nextState = run;
        end
      end
      run:
      begin
        if (lastStep)
        begin
          nextState = md4Pkg::finish;
        end
      end
      default:
      begin
        nextState = idle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= idle;
      done <= 1'b0;
    end
    else
    begin
      state <= nextState;
      // done trails the finish cycle by one edge
      done <= finish;
    end
  end

endmodule

// File: md4StepCounter.sv
`timescale 1ns/100ps
`include "md4_defs.svh"

module md4StepCounter (
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic stepEn,
  output logic [5:0] step,
  output logic lastStep
);

  localparam logic [5:0] LastIdx = 6'(`MD4_STEPS - 1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      step <= '0;
    end
    else if (load)
    begin
      step <= '0;
    end
    else if (stepEn)
    begin
      step <= step + 6'd1;
    end
  end

  // high while step 47 is being executed
  assign lastStep = (step == LastIdx);

endmodule

// File: md4Schedule.sv
`timescale 1ns/100ps
`include "md4_defs.svh"

module md4Schedule (
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic finish,
  input  md4Pkg::blockT block,
  input  logic [5:0] step,
  output logic [`MD4_WORD_W-1:0] msgWord,
  output logic [4:0] rotAmount,
  output md4Pkg::roundFuncT roundFunc,
  output logic [127:0] passwordText
);
  import md4Pkg::*;

  blockT blockReg;
  logic [1:0] round;
  logic [3:0] pos;
  logic [3:0] wordIdx;

  assign round = step[5:4];
  assign pos = step[3:0];

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      blockReg <= block;
    end
  end

  // round 2 swaps the two halves of pos, round 3 reverses its bits
  always_comb
  begin
    case (round)
      2'd0:
      begin
        wordIdx = pos;
        roundFunc = funcF;
      end
      2'd1:
      begin
        wordIdx = {pos[1:0], pos[3:2]};
        roundFunc = funcG;
      end
      default:
      begin
        wordIdx = {pos[0], pos[1], pos[2], pos[3]};
        roundFunc = funcH;
      end
    endcase
  end

  assign msgWord = blockReg[wordIdx];

  always_comb
  begin
    case ({round, pos[1:0]})
      4'b00_00: rotAmount = 5'd3;
      4'b00_01: rotAmount = 5'd7;
      4'b00_10: rotAmount = 5'd11;
      4'b00_11: rotAmount = 5'd19;
      4'b01_00: rotAmount = 5'd3;
      4'b01_01: rotAmount = 5'd5;
      4'b01_10: rotAmount = 5'd9;
      4'b01_11: rotAmount = 5'd13;
      4'b10_00: rotAmount = 5'd3;
      4'b10_01: rotAmount = 5'd9;
      4'b10_10: rotAmount = 5'd11;
      default: rotAmount = 5'd15;
    endcase
  end

  // low byte of two UTF-16 characters per word, word 7 on top
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      passwordText <= '0;
    end
    else if (finish)
    begin
      for (int i = 0; i < 8; i++)
      begin
        passwordText[i*16 +: 16] <= {blockReg[i][23:16], blockReg[i][7:0]};
      end
    end
  end

endmodule

// File: md4RoundStep.sv
`timescale 1ns/100ps
`include "md4_defs.svh"

module md4RoundStep (
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic stepEn,
  input  logic finish,
  input  md4Pkg::digestT initDigest,
  input  logic [`MD4_WORD_W-1:0] msgWord,
  input  logic [4:0] rotAmount,
  input  md4Pkg::roundFuncT roundFunc,
  output md4Pkg::digestT digest
);
  import md4Pkg::*;

  digestT work;
  digestT chain;
  logic [`MD4_WORD_W-1:0] funcOut;
  logic [`MD4_WORD_W-1:0] roundK;
  logic [`MD4_WORD_W-1:0] sum;
  logic [`MD4_WORD_W-1:0] newB;

  always_comb
  begin
    case (roundFunc)
      funcF:
      begin
        funcOut = (work.b & work.c) | (~work.b & work.d);
        roundK = '0;
      end
      funcG:
      begin
        funcOut = (work.b & work.c) | (work.b & work.d) | (work.c & work.d);
        roundK = `MD4_K2;
      end
      default:
      begin
        funcOut = work.b ^ work.c ^ work.d;
        roundK = `MD4_K3;
      end
    endcase
  end

  assign sum = work.a + funcOut + roundK + msgWord;

  // rotate left, rotAmount is never zero
  assign newB = (sum << rotAmount) | (sum >> (6'd32 - {1'b0, rotAmount}));

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      work <= initDigest;
      chain <= initDigest;
    end
    else if (stepEn)
    begin
      work.a <= work.d;
      work.d <= work.c;
      work.c <= work.b;
      work.b <= newB;
    end
  end

  // feed-forward of the chaining value held with the block
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      digest <= '0;
    end
    else if (finish)
    begin
      digest.a <= work.a + chain.a;
      digest.b <= work.b + chain.b;
      digest.c <= work.c + chain.c;
      digest.d <= work.d + chain.d;
    end
  end

endmodule

// File: md4Core.sv
`timescale 1ns/100ps
`include "md4_defs.svh"

module md4Core (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  md4Pkg::blockT block,
  input  md4Pkg::digestT initDigest,
  output logic done,
  output md4Pkg::digestT digest,
  output logic [127:0] passwordText
);
  import md4Pkg::*;

  logic load;
  logic stepEn;
  logic finish;
  logic lastStep;
  logic [5:0] step;
  logic [`MD4_WORD_W-1:0] msgWord;
  logic [4:0] rotAmount;
  roundFuncT roundFunc;

  md4Control control (
    .clk(clk),
    .rst(rst),
    .start(start),
    .lastStep(lastStep),
    .load(load),
    .stepEn(stepEn),
    .finish(finish),
    .done(done)
  );

  md4StepCounter stepCounter (
    .clk(clk),
    .rst(rst),
    .load(load),
    .stepEn(stepEn),
    .step(step),
    .lastStep(lastStep)
  );

  md4Schedule schedule (
    .clk(clk),
    .rst(rst),
    .load(load),
    .finish(finish),
    .block(block),
    .step(step),
    .msgWord(msgWord),
    .rotAmount(rotAmount),
    .roundFunc(roundFunc),
    .passwordText(passwordText)
  );

  md4RoundStep roundStep (
    .clk(clk),
    .rst(rst),
    .load(load),
    .stepEn(stepEn),
    .finish(finish),
    .initDigest(initDigest),
    .msgWord(msgWord),
    .rotAmount(rotAmount),
    .roundFunc(roundFunc),
    .digest(digest)
  );

endmodule

// File: md4Core_chk.sv
`timescale 1ns/100ps
`include "md4_defs.svh"

module md4Core_chk (
  input logic clk,
  input logic rst,
  input logic load,
  input logic done
);

  int violations = 0;

  // done is a single-cycle strobe
  assert property (@(posedge clk) disable iff (rst) done |=> !done)
  else
  begin
    $error("done stayed high for two cycles");
    violations++;
  end

  // sampled done lags its register by one edge
  assert property (@(posedge clk) disable iff (rst)
    load |-> ##(`MD4_DONE_LATENCY + 1) $rose(done))
  else
  begin
    $error("done did not follow an accepted start at the expected latency");
    violations++;
  end

  assert property (@(posedge clk) disable iff (rst)
    $rose(done) |-> $past(load, `MD4_DONE_LATENCY + 1))
  else
  begin
    $error("done rose without an accepted start");
    violations++;
  end

  assert property (@(posedge clk) rst |=> !done)
  else
  begin
    $error("done was high right after reset");
    violations++;
  end

endmodule

bind md4Core md4Core_chk chk (
  .clk(clk),
  .rst(rst),
  .load(load),
  .done(done)
);

// File: md4Tb.sv
`timescale 1ns/100ps
`include "md4_defs.svh"

module md4Tb;
  import md4Pkg::*;

  localparam int ClkPeriod = 4;
  localparam int NumBlocks = 38;
  localparam int WaitCycles = `MD4_DONE_LATENCY + 10;
  localparam int WatchdogCycles = NumBlocks * WaitCycles + 200;

  localparam int ShiftR1 [4] = '{3, 7, 11, 19};
  localparam int ShiftR2 [4] = '{3, 5, 9, 13};
  localparam int ShiftR3 [4] = '{3, 9, 11, 15};
  localparam int OrderR3 [16] = '{0, 8, 4, 12, 2, 10, 6, 14, 1, 9, 5, 13, 3, 11, 7, 15};

  logic clk = 1'b0;
  logic rst;
  logic start;
  blockT block;
  digestT initDigest;
  logic done;
  digestT digest;
  logic [127:0] passwordText;

  integer seed = 32'hbb22;
  int errors = 0;
  int testStartErrors;
  int testsPassed = 0;
  int testsFailed = 0;
  string testName;
  digestT stdInit;

  md4Core dut (
    .clk(clk),
    .rst(rst),
    .start(start),
    .block(block),
    .initDigest(initDigest),
    .done(done),
    .digest(digest),
    .passwordText(passwordText)
  );

  initial
  begin
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] rotl(input logic [31:0] x, input int s);
    return (x << s) | (x >> (32 - s));
  endfunction

  // reference compression written from the MD4 round description
  function automatic digestT compress(input blockT blk, input digestT iv);
    logic [31:0] v [4];
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] z;
    logic [31:0] f;
    logic [31:0] k;
    int j;
    int t;
    int idx;
    int s;
    digestT res;
    v[0] = iv.a;
    v[1] = iv.b;
    v[2] = iv.c;
    v[3] = iv.d;
    for (int i = 0; i < 48; i++)
    begin
      j = i % 16;
      // the target walks backwards through a, d, c, b
      t = (4 - (i % 4)) % 4;
      x = v[(t + 1) % 4];
      y = v[(t + 2) % 4];
      z = v[(t + 3) % 4];
      if (i < 16)
      begin
        f = (x & y) | (~x & z);
        k = 32'h0;
        idx = j;
        s = ShiftR1[j % 4];
      end
      else if (i < 32)
      begin
        f = (x & y) | (x & z) | (y & z);
        k = 32'h5a827999;
        idx = (j % 4) * 4 + j / 4;
        s = ShiftR2[j % 4];
      end
      else
      begin
        f = x ^ y ^ z;
        k = 32'h6ed9eba1;
        idx = OrderR3[j];
        s = ShiftR3[j % 4];
      end
      v[t] = rotl(v[t] + f + k + blk[idx], s);
    end
    res.a = v[0] + iv.a;
    res.b = v[1] + iv.b;
    res.c = v[2] + iv.c;
    res.d = v[3] + iv.d;
    return res;
  endfunction

  // character k is word k/2, even characters in the low half
  function automatic logic [127:0] textOf(input blockT blk);
    logic [127:0] text;
    logic [31:0] w;
    text = '0;
    for (int k = 0; k < 16; k++)
    begin
      w = blk[k / 2];
      text[k*8 +: 8] = w[(k % 2)*16 +: 8];
    end
    return text;
  endfunction

  task automatic randomBlock(output blockT blk);
    for (int w = 0; w < 16; w++)
    begin
      blk[w] = $random(seed);
    end
  endtask

  task automatic randomDigest(output digestT dg);
    dg.a = $random(seed);
    dg.b = $random(seed);
    dg.c = $random(seed);
    dg.d = $random(seed);
  endtask

  // call on a falling edge, returns on the next one
  task automatic startBlock(input blockT blk, input digestT iv);
    start = 1'b1;
    block = blk;
    initDigest = iv;
    @(negedge clk);
    start = 1'b0;
  endtask

  // returns on the falling edge where done is high, or after the timeout
  task automatic awaitDone();
    int n;
    n = 0;
    while (!done && n < WaitCycles)
    begin
      @(negedge clk);
      n++;
    end
    assert (done)
    else
    begin
      $display("done did not arrive within %0d cycles of start", WaitCycles);
      errors++;
    end
  endtask

  task automatic checkOutputs(input blockT blk, input digestT iv);
    digestT expDigest;
    logic [127:0] expText;
    expDigest = compress(blk, iv);
    expText = textOf(blk);
    assert (digest == expDigest)
    else
    begin
      $display("FAILED at %0t: digest %h, expected %h", $time, digest, expDigest);
      errors++;
    end
    assert (passwordText == expText)
    else
    begin
      $display("FAILED at %0t: password text %h, expected %h", $time, passwordText, expText);
      errors++;
    end
  endtask

  task automatic runBlock(input blockT blk, input digestT iv);
    @(negedge clk);
    startBlock(blk, iv);
    awaitDone();
    checkOutputs(blk, iv);
  endtask

  task automatic beginTest(input string name);
    testName = name;
    testStartErrors = errors;
  endtask

  task automatic endTest();
    if (errors == testStartErrors)
    begin
      testsPassed++;
      $display("%s: ok", testName);
    end
    else
    begin
      testsFailed++;
      $display("%s: %0d errors", testName, errors - testStartErrors);
    end
  endtask

  initial
  begin
    #(WatchdogCycles * ClkPeriod);
    $display("simulation timed out after %0d cycles", WatchdogCycles);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    blockT blk;
    blockT other;
    digestT iv;
    int extraDone;
    rst = 1'b1;
    start = 1'b0;
    block = '0;
    initDigest = '0;
    stdInit.a = 32'h67452301;
    stdInit.b = 32'hefcdab89;
    stdInit.c = 32'h98badcfe;
    stdInit.d = 32'h10325476;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    beginTest("empty password");
    blk = '0;
    blk[0] = 32'h00000080;
    @(negedge clk);
    startBlock(blk, stdInit);
    awaitDone();
    checkOutputs(blk, stdInit);
    // little-endian words of 31d6cfe0d16ae931b73c59d7e0c089c0
    assert (digest == {32'he0cfd631, 32'h31e96ad1, 32'hd7593cb7, 32'hc089c0e0})
    else
    begin
      $display("FAILED at %0t: empty password hash %h", $time, digest);
      errors++;
    end
    endTest();

    beginTest("random blocks, standard init");
    for (int n = 0; n < 20; n++)
    begin
      randomBlock(blk);
      runBlock(blk, stdInit);
    end
    endTest();

    beginTest("random blocks, random chaining");
    for (int n = 0; n < 10; n++)
    begin
      randomBlock(blk);
      randomDigest(iv);
      runBlock(blk, iv);
    end
    endTest();

    beginTest("start during run");
    randomBlock(blk);
    randomBlock(other);
    randomDigest(iv);
    @(negedge clk);
    startBlock(blk, stdInit);
    repeat (10) @(negedge clk);
    startBlock(other, iv);
    awaitDone();
    checkOutputs(blk, stdInit);
    extraDone = 0;
    repeat (WaitCycles) @(negedge clk)
    begin
      if (done)
      begin
        extraDone++;
      end
    end
    assert (extraDone == 0)
    else
    begin
      $display("a second done followed the ignored start");
      errors++;
    end
    endTest();

    beginTest("back-to-back blocks");
    @(negedge clk);
    for (int n = 0; n < 6; n++)
    begin
      randomBlock(blk);
      startBlock(blk, stdInit);
      awaitDone();
      checkOutputs(blk, stdInit);
    end
    endTest();

    assert (dut.chk.violations == 0)
    else
    begin
      $display("the bound checker reported %0d assertion failures", dut.chk.violations);
      testsFailed++;
    end
    $display("tests passed %0d, tests failed %0d", testsPassed, testsFailed);
    if (testsFailed == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+.
md4Pkg.sv
md4Control.sv
md4StepCounter.sv
md4Schedule.sv
md4RoundStep.sv
md4Core.sv
md4Core_chk.sv
md4Tb.sv

// File: Makefile
# Verilator build and run for the MD4 core testbench

VERILATOR ?= verilator
TOP ?= md4Tb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
RUNFLAGS ?= +verilator+error+limit+100
PASS_MSG ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
